//--- src/scrypt_cfg_pkg.sv
// Scrypt configuration package
// Sizes of the Salsa words, the 1024-bit block, the scratchpad and the byte-wide shift path
package scrypt_cfg_pkg;

	// Salsa20/8 word and half-block geometry
	localparam int WORD_BITS   = 32;   // One Salsa word
	localparam int HALF_WORDS  = 16;   // Words in X0 or X1
	localparam int BLOCK_WORDS = 2 * HALF_WORDS;   // Words in the full X block
	localparam int BLOCK_BITS  = BLOCK_WORDS * WORD_BITS;   // 1024 bits for r = 1

	// Host shift path is one byte wide
	localparam int SHIFT_BITS = 8;

	// ROMix scratchpad, N = 1024 entries of one full block each
	localparam int SCRATCH_DEPTH = 1024;
	localparam int ADDR_BITS     = $clog2(SCRATCH_DEPTH);   // 10 address bits
	localparam int BANKS         = 4;   // Block RAM tops out at 256 bits wide
	localparam int BANK_BITS     = BLOCK_BITS / BANKS;

	// Salsa20/8 runs four column/row double rounds
	localparam int DOUBLE_ROUNDS = 4;

	typedef logic [WORD_BITS-1:0] word_t;

	// Word 0 sits in the low bits, matching the little-endian word layout of scrypt
	typedef word_t [HALF_WORDS-1:0] salsa_half_t;

	// X1 is the upper half of the block, X0 the lower
	typedef struct packed {
		salsa_half_t x1;
		salsa_half_t x0;
	} block_t;

	typedef logic [BANK_BITS-1:0] bank_data_t;   // One bank's quarter of a block

	typedef logic [ADDR_BITS-1:0] scratch_addr_t;

endpackage

//--- src/romix_ctl_pkg.sv
// ROMix control package
// Sequencer states, BlockMix operation codes and the scratchpad request shared by all banks
package romix_ctl_pkg;

	// Idle waits for start, write fills V[0..N-1], mix runs the N dependent reads
	typedef enum logic [1:0] {
		idle  = 2'd0,
		write = 2'd1,
		mix   = 2'd2
	} romix_state_t;

	// Plain mixes X as it stands, xor_ram folds the scratchpad block in first
	typedef enum logic {
		plain   = 1'b0,
		xor_ram = 1'b1
	} mix_op_t;

	// One address and write enable drive all four banks in parallel
	typedef struct packed {
		scrypt_cfg_pkg::scratch_addr_t addr;   // Write index in the write pass, j in the mix pass
		logic                          wren;
	} bank_req_t;

endpackage

//--- src/salsa_core.sv
// Iterative Salsa20/8 core on one 512-bit half
// One double round per cycle, then the feed-forward add of the saved input
`timescale 1ns/1ps

module salsa_core (
	input  logic                        hash_clk,
	input  logic                        fsmreset,
	input  logic                        core_go,
	input  scrypt_cfg_pkg::salsa_half_t core_in,
	output scrypt_cfg_pkg::salsa_half_t core_out,
	output logic                        core_done
);

	scrypt_cfg_pkg::salsa_half_t state;   // Working words between rounds
	scrypt_cfg_pkg::salsa_half_t saved;   // Input kept for the final add
	scrypt_cfg_pkg::salsa_half_t out_q;

	logic       active;
	logic [2:0] rounds;   // Double rounds applied so far

	function automatic scrypt_cfg_pkg::word_t rotl(input scrypt_cfg_pkg::word_t v, input int n);
		return (v << n) | (v >> (scrypt_cfg_pkg::WORD_BITS - n));
	endfunction

	// Salsa quarter round on the words at indices a, b, c and d
	function automatic scrypt_cfg_pkg::salsa_half_t quarter_round(
		input scrypt_cfg_pkg::salsa_half_t x,
		input int a, input int b, input int c, input int d
	);
		scrypt_cfg_pkg::salsa_half_t y;
		y = x;
		y[b] = y[b] ^ rotl(y[a] + y[d], 7);
		y[c] = y[c] ^ rotl(y[b] + y[a], 9);
		y[d] = y[d] ^ rotl(y[c] + y[b], 13);
		y[a] = y[a] ^ rotl(y[d] + y[c], 18);
		return y;
	endfunction

	function automatic scrypt_cfg_pkg::salsa_half_t double_round(
		input scrypt_cfg_pkg::salsa_half_t x
	);
		scrypt_cfg_pkg::salsa_half_t y;
		y = x;
		// Column round
		y = quarter_round(y, 0, 4, 8, 12);
		y = quarter_round(y, 5, 9, 13, 1);
		y = quarter_round(y, 10, 14, 2, 6);
		y = quarter_round(y, 15, 3, 7, 11);
		// Row round works on the result of the columns
		y = quarter_round(y, 0, 1, 2, 3);
		y = quarter_round(y, 5, 6, 7, 4);
		y = quarter_round(y, 10, 11, 8, 9);
		y = quarter_round(y, 15, 12, 13, 14);
		return y;
	endfunction

	// Word-wise add, carries stay inside each word
	function automatic scrypt_cfg_pkg::salsa_half_t feed_forward(
		input scrypt_cfg_pkg::salsa_half_t a,
		input scrypt_cfg_pkg::salsa_half_t b
	);
		scrypt_cfg_pkg::salsa_half_t s;
		for (int w = 0; w < scrypt_cfg_pkg::HALF_WORDS; w++)
		begin
			s[w] = a[w] + b[w];
		end
		return s;
	endfunction

	always_ff @(posedge hash_clk)
	begin
		if (fsmreset)
		begin
			active    <= 1'b0;
			rounds    <= '0;
			core_done <= 1'b0;
		end
		else
		begin
			core_done <= 1'b0;   // Done is a single-cycle pulse
			if (core_go)
			begin
				active <= 1'b1;
				rounds <= 3'd1;   // First double round happens on the go edge
			end
			else if (active && rounds == 3'(scrypt_cfg_pkg::DOUBLE_ROUNDS))
			begin
				active    <= 1'b0;
				core_done <= 1'b1;   // Lands five cycles after core_go
			end
			else if (active)
				rounds <= rounds + 3'd1;
		end
	end

	// Round datapath, loaded on core_go and stepped while active
	always_ff @(posedge hash_clk)
	begin
		if (core_go)
		begin
			saved <= core_in;
			state <= double_round(core_in);
		end
		else if (active && rounds == 3'(scrypt_cfg_pkg::DOUBLE_ROUNDS))
			out_q <= feed_forward(state, saved);   // Final add after the fourth double round
		else if (active)
			state <= double_round(state);
	end

	assign core_out = out_q;

endmodule

//--- src/block_mixer.sv
// Scrypt BlockMix for r = 1
// Holds X0 and X1, folds in the scratchpad block and runs the Salsa core twice per mix
`timescale 1ns/1ps

module block_mixer (
	input  logic                          hash_clk,
	input  logic                          fsmreset,
	input  logic                          load_x,
	input  scrypt_cfg_pkg::block_t        load_block,
	input  logic                          mix_go,
	input  romix_ctl_pkg::mix_op_t        mix_op,
	input  scrypt_cfg_pkg::block_t        ram_block,
	output scrypt_cfg_pkg::block_t        x,
	output scrypt_cfg_pkg::scratch_addr_t j_index,
	output logic                          mix_done
);

	scrypt_cfg_pkg::salsa_half_t x0;
	scrypt_cfg_pkg::salsa_half_t x1;
	scrypt_cfg_pkg::salsa_half_t core_out;

	logic go_first;    // Core start after the setup cycle
	logic go_second;   // Core start after X0 has been replaced
	logic second;      // Core is on the X1 pass
	logic core_done;

	// Both passes feed the core X0 xor X1, X0 is already the new one on the second
	salsa_core i_salsa_core (
		.hash_clk  (hash_clk),
		.fsmreset  (fsmreset),
		.core_go   (go_first | go_second),
		.core_in   (x0 ^ x1),
		.core_out  (core_out),
		.core_done (core_done)
	);

	always_ff @(posedge hash_clk)
	begin
		if (fsmreset)
		begin
			go_first  <= 1'b0;
			go_second <= 1'b0;
			second    <= 1'b0;
		end
		else
		begin
			go_first  <= mix_go;
			go_second <= core_done & ~second;   // One cycle gap for the new X0 to settle
			if (core_done)
				second <= ~second;
		end
	end

	always_ff @(posedge hash_clk)
	begin
		if (load_x)
		begin
			x0 <= load_block.x0;
			x1 <= load_block.x1;
		end
		else if (mix_go && mix_op == romix_ctl_pkg::xor_ram)
		begin
			x0 <= x0 ^ ram_block.x0;   // Bank read data is valid in the mix_go cycle
			x1 <= x1 ^ ram_block.x1;
		end
		else if (core_done && !second)
			x0 <= core_out;
		else if (core_done)
			x1 <= core_out;
	end

	assign x        = '{x1: x1, x0: x0};
	assign j_index  = x1[0][scrypt_cfg_pkg::ADDR_BITS-1:0];   // Integerify, N is a power of two
	assign mix_done = core_done & second;   // Twelve cycles after mix_go

endmodule

//--- src/scratchpad_bank.sv
// Scratchpad bank holding one quarter of every stored block
// Single write port and a registered read that returns old data on a collision
`timescale 1ns/1ps

module scratchpad_bank (
	input  logic                     hash_clk,
	input  romix_ctl_pkg::bank_req_t bank_req,
	input  scrypt_cfg_pkg::bank_data_t wr_data,
	output scrypt_cfg_pkg::bank_data_t rd_data
);

	scrypt_cfg_pkg::bank_data_t mem [scrypt_cfg_pkg::SCRATCH_DEPTH];

	always_ff @(posedge hash_clk)
	begin
		if (bank_req.wren)
			mem[bank_req.addr] <= wr_data;
		rd_data <= mem[bank_req.addr];   // Read before write on the same address
	end

endmodule

//--- src/romix_ctl.sv
// ROMix sequencer
// Fills the scratchpad in the write pass, then runs the N dependent reads of the mix pass
`timescale 1ns/1ps

module romix_ctl (
	input  logic                          hash_clk,
	input  logic                          fsmreset,
	input  logic                          start,
	input  logic                          mix_done,
	input  scrypt_cfg_pkg::scratch_addr_t j_index,
	output romix_ctl_pkg::bank_req_t      bank_req,
	output logic                          mix_go,
	output romix_ctl_pkg::mix_op_t        mix_op,
	output logic                          load_x,
	output logic                          busy,
	output logic                          result
);

	romix_ctl_pkg::romix_state_t   state;
	scrypt_cfg_pkg::scratch_addr_t iter;   // Write index, then mix pass count

	logic armed;     // Read address for V[j] went out last cycle
	logic waiting;   // BlockMix in flight
	logic last;

	assign last = (iter == scrypt_cfg_pkg::ADDR_BITS'(scrypt_cfg_pkg::SCRATCH_DEPTH - 1));

	always_ff @(posedge hash_clk)
	begin
		if (fsmreset)
		begin
			state   <= romix_ctl_pkg::idle;
			iter    <= '0;
			armed   <= 1'b0;
			waiting <= 1'b0;
			busy    <= 1'b0;
			result  <= 1'b0;
		end
		else
		begin
			result <= 1'b0;   // Result only ever pulses for one cycle
			case (state)
				romix_ctl_pkg::idle:
				begin
					if (start)
					begin
						state   <= romix_ctl_pkg::write;   // X is loaded on this same edge
						iter    <= '0;
						armed   <= 1'b0;
						waiting <= 1'b0;
						busy    <= 1'b1;
					end
				end
				romix_ctl_pkg::write:
				begin
					if (!waiting)
						waiting <= 1'b1;   // V[i] written and BlockMix started together
					else if (mix_done)
					begin
						waiting <= 1'b0;
						iter    <= iter + 1'b1;   // Wraps to zero for the mix pass
						if (last)
							state <= romix_ctl_pkg::mix;
					end
				end
				romix_ctl_pkg::mix:
				begin
					if (waiting)
					begin
						if (mix_done)
						begin
							waiting <= 1'b0;
							iter    <= iter + 1'b1;   // Wraps back to zero after the last pass
							if (last)
							begin
								state  <= romix_ctl_pkg::idle;
								busy   <= 1'b0;
								result <= 1'b1;   // Mixer X is final from the next cycle on
							end
						end
					end
					else if (armed)
					begin
						armed   <= 1'b0;
						waiting <= 1'b1;
					end
					else
						armed <= 1'b1;   // j_index from the previous mix is on the address bus
				end
				default:
					state <= romix_ctl_pkg::idle;
			endcase
		end
	end

	// Start is only taken in idle, a start while busy has no effect
	assign load_x = (state == romix_ctl_pkg::idle) && start;

	assign mix_go = !waiting && ((state == romix_ctl_pkg::write) ||
		(state == romix_ctl_pkg::mix && armed));
	assign mix_op = (state == romix_ctl_pkg::mix) ? romix_ctl_pkg::xor_ram : romix_ctl_pkg::plain;

	assign bank_req.addr = (state == romix_ctl_pkg::write) ? iter : j_index;
	assign bank_req.wren = (state == romix_ctl_pkg::write) && !waiting;

endmodule

//--- src/salsa_engine.sv
// Scrypt ROMix engine top level, N = 1024
// Byte-wide shift path in and out, per-word byte swap and four scratchpad banks
`timescale 1ns/1ps

module salsa_engine (
	input  logic                                  hash_clk,
	input  logic                                  fsmreset,
	input  logic [scrypt_cfg_pkg::SHIFT_BITS-1:0] din,
	input  logic                                  shift,
	input  logic                                  start,
	output logic [scrypt_cfg_pkg::SHIFT_BITS-1:0] dout,
	output logic                                  busy,
	output logic                                  result
);

	logic [scrypt_cfg_pkg::BLOCK_BITS-1:0] shift_reg;   // Host side, big-endian words

	scrypt_cfg_pkg::block_t        x;
	scrypt_cfg_pkg::block_t        load_block;
	scrypt_cfg_pkg::block_t        ram_block;
	scrypt_cfg_pkg::scratch_addr_t j_index;
	romix_ctl_pkg::bank_req_t      bank_req;
	romix_ctl_pkg::mix_op_t        mix_op;
	logic                          mix_go;
	logic                          mix_done;
	logic                          load_x;

	scrypt_cfg_pkg::bank_data_t [scrypt_cfg_pkg::BANKS-1:0] wr_slices;
	scrypt_cfg_pkg::bank_data_t [scrypt_cfg_pkg::BANKS-1:0] rd_slices;

	// Reverses the bytes inside every 32-bit word, the same in both directions
	function automatic logic [scrypt_cfg_pkg::BLOCK_BITS-1:0] word_swap(
		input logic [scrypt_cfg_pkg::BLOCK_BITS-1:0] v
	);
		logic [scrypt_cfg_pkg::BLOCK_BITS-1:0] r;
		scrypt_cfg_pkg::word_t wd;
		for (int w = 0; w < scrypt_cfg_pkg::BLOCK_WORDS; w++)
		begin
			wd = v[w*scrypt_cfg_pkg::WORD_BITS +: scrypt_cfg_pkg::WORD_BITS];
			r[w*scrypt_cfg_pkg::WORD_BITS +: scrypt_cfg_pkg::WORD_BITS] =
				{wd[7:0], wd[15:8], wd[23:16], wd[31:24]};
		end
		return r;
	endfunction

	always_ff @(posedge hash_clk)
	begin
		if (result)
			shift_reg <= word_swap(x);   // Final X goes back out in host byte order
		else if (shift)
			shift_reg <= {shift_reg[scrypt_cfg_pkg::BLOCK_BITS-scrypt_cfg_pkg::SHIFT_BITS-1:0], din};
	end

	assign dout       = shift_reg[scrypt_cfg_pkg::BLOCK_BITS-1 -: scrypt_cfg_pkg::SHIFT_BITS];
	assign load_block = word_swap(shift_reg);

	romix_ctl i_romix_ctl (
		.hash_clk (hash_clk),
		.fsmreset (fsmreset),
		.start    (start),
		.mix_done (mix_done),
		.j_index  (j_index),
		.bank_req (bank_req),
		.mix_go   (mix_go),
		.mix_op   (mix_op),
		.load_x   (load_x),
		.busy     (busy),
		.result   (result)
	);

	block_mixer i_block_mixer (
		.hash_clk   (hash_clk),
		.fsmreset   (fsmreset),
		.load_x     (load_x),
		.load_block (load_block),
		.mix_go     (mix_go),
		.mix_op     (mix_op),
		.ram_block  (ram_block),
		.x          (x),
		.j_index    (j_index),
		.mix_done   (mix_done)
	);

	assign wr_slices = x;   // Bank 0 takes the low 256 bits of X0
	assign ram_block = scrypt_cfg_pkg::block_t'(rd_slices);

	for (genvar k = 0; k < scrypt_cfg_pkg::BANKS; k++)
	begin : g_bank
		scratchpad_bank i_bank (
			.hash_clk (hash_clk),
			.bank_req (bank_req),
			.wr_data  (wr_slices[k]),
			.rd_data  (rd_slices[k])
		);
	end

endmodule

//--- sim/tb_clock_gen.sv
// Testbench clock and reset source
// hash_clk at a 40 ns period, fsmreset held high for the first 16 cycles
`timescale 1ns/1ps

module tb_clock_gen (
	output logic hash_clk,
	output logic fsmreset
);

	localparam int HALF_PERIOD  = 20;   // ns
	localparam int RESET_CYCLES = 16;

	initial
	begin
		hash_clk = 1'b0;
		forever #(HALF_PERIOD) hash_clk = ~hash_clk;
	end

	initial
	begin
		fsmreset = 1'b1;
		repeat (RESET_CYCLES) @(posedge hash_clk);
		#2 fsmreset = 1'b0;   // Released just after the edge like every other input
	end

endmodule

//--- sim/salsa_engine_checker.sv
// Protocol checker bound to the engine top level
// Shifting only while idle, result ends busy, and reset leaves the engine idle
`timescale 1ns/1ps

module salsa_engine_checker (
	input logic hash_clk,
	input logic fsmreset,
	input logic shift,
	input logic busy,
	input logic result
);

	int unsigned error_count = 0;   // Failed assertions so far

	a_shift_idle: assert property (@(posedge hash_clk) disable iff (fsmreset) !(shift && busy))
	else
	begin
		error_count++;
		$error("shift was high while the engine was busy");
	end

	// Result and the falling edge of busy come on the same clock
	a_result_ends_busy: assert property (@(posedge hash_clk) disable iff (fsmreset)
		result |-> !busy && $past(busy))
	else
	begin
		error_count++;
		$error("result was high without busy falling in the same cycle");
	end

	a_reset_idle: assert property (@(posedge hash_clk) fsmreset |=> !busy && !result)
	else
	begin
		error_count++;
		$error("busy or result was high after reset");
	end

endmodule

//--- sim/scrypt_model.svh
// Reference scrypt model for the testbench
// Salsa20/8, BlockMix and ROMix with N = 1024, plus the host byte order of the shift path
`ifndef SCRYPT_MODEL_SVH
`define SCRYPT_MODEL_SVH

localparam int HOST_BYTES = scrypt_cfg_pkg::BLOCK_BITS / scrypt_cfg_pkg::SHIFT_BITS;

typedef logic [scrypt_cfg_pkg::SHIFT_BITS-1:0] host_bytes_t [HOST_BYTES];   // In shift order

function automatic scrypt_cfg_pkg::word_t rotate_left(input scrypt_cfg_pkg::word_t v,
	input int n);
	return (v << n) | (v >> (32 - n));
endfunction

function automatic scrypt_cfg_pkg::salsa_half_t salsa20_8(
	input scrypt_cfg_pkg::salsa_half_t h
);
	// Quarter rounds as a, b, c, d word indices, four columns and then four rows
	int order [32] = '{0, 4, 8, 12, 5, 9, 13, 1, 10, 14, 2, 6, 15, 3, 7, 11,
		0, 1, 2, 3, 5, 6, 7, 4, 10, 11, 8, 9, 15, 12, 13, 14};
	scrypt_cfg_pkg::word_t x [16];
	scrypt_cfg_pkg::salsa_half_t s;
	int a;
	int b;
	int c;
	int d;
	for (int w = 0; w < 16; w++)
		x[w] = h[w];
	for (int r = 0; r < scrypt_cfg_pkg::DOUBLE_ROUNDS; r++)
	begin
		for (int q = 0; q < 8; q++)
		begin
			a = order[4*q];
			b = order[4*q+1];
			c = order[4*q+2];
			d = order[4*q+3];
			x[b] = x[b] ^ rotate_left(x[a] + x[d], 7);
			x[c] = x[c] ^ rotate_left(x[b] + x[a], 9);
			x[d] = x[d] ^ rotate_left(x[c] + x[b], 13);
			x[a] = x[a] ^ rotate_left(x[d] + x[c], 18);
		end
	end
	for (int w = 0; w < 16; w++)
		s[w] = x[w] + h[w];   // Feed-forward of the input words
	return s;
endfunction

function automatic scrypt_cfg_pkg::block_t block_mix(input scrypt_cfg_pkg::block_t b);
	scrypt_cfg_pkg::block_t r;
	r.x0 = salsa20_8(b.x0 ^ b.x1);
	r.x1 = salsa20_8(b.x1 ^ r.x0);   // Second half uses the new X0
	return r;
endfunction

function automatic scrypt_cfg_pkg::block_t romix(input scrypt_cfg_pkg::block_t b);
	scrypt_cfg_pkg::block_t v [scrypt_cfg_pkg::SCRATCH_DEPTH];
	scrypt_cfg_pkg::block_t x;
	int j;
	x = b;
	for (int i = 0; i < scrypt_cfg_pkg::SCRATCH_DEPTH; i++)
	begin
		v[i] = x;
		x = block_mix(x);
	end
	for (int i = 0; i < scrypt_cfg_pkg::SCRATCH_DEPTH; i++)
	begin
		j = int'(x.x1[0] % scrypt_cfg_pkg::SCRATCH_DEPTH);   // Integerify on word 0 of X1
		x = block_mix(x ^ v[j]);
	end
	return x;
endfunction

// Byte p lands in word 31 - p/4, first byte of each group as the least significant
function automatic scrypt_cfg_pkg::block_t bytes_to_block(input host_bytes_t h);
	logic [scrypt_cfg_pkg::BLOCK_BITS-1:0] flat;
	for (int p = 0; p < HOST_BYTES; p++)
		flat[(scrypt_cfg_pkg::BLOCK_WORDS - 1 - p / 4) * 32 + 8 * (p % 4) +: 8] = h[p];
	return scrypt_cfg_pkg::block_t'(flat);
endfunction

`endif

//--- sim/tb_salsa_engine.sv
// Testbench for the scrypt ROMix engine
// LFSR blocks go through the byte shift path and every hash is compared with the ROMix model
`timescale 1ns/1ps

module tb_salsa_engine;

	localparam int          DRIVE_DELAY    = 2;   // ns after the rising edge
	localparam int          RESET_TIMEOUT  = 64;
	localparam int          RESULT_TIMEOUT = 40000;   // Well above 2N BlockMix runs
	localparam logic [31:0] LFSR_SEED      = 32'd87159;
	localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1

	logic                                  hash_clk;
	logic                                  fsmreset;
	logic [scrypt_cfg_pkg::SHIFT_BITS-1:0] din;
	logic                                  shift;
	logic                                  start;
	logic [scrypt_cfg_pkg::SHIFT_BITS-1:0] dout;
	logic                                  busy;
	logic                                  result;
	logic [31:0]                           lfsr_state;

	`include "scrypt_model.svh"

	tb_clock_gen i_clock_gen (.hash_clk (hash_clk), .fsmreset (fsmreset));

	salsa_engine i_dut (
		.hash_clk (hash_clk),
		.fsmreset (fsmreset),
		.din      (din),
		.shift    (shift),
		.start    (start),
		.dout     (dout),
		.busy     (busy),
		.result   (result)
	);

	bind salsa_engine salsa_engine_checker i_checker (
		.hash_clk (hash_clk),
		.fsmreset (fsmreset),
		.shift    (shift),
		.busy     (busy),
		.result   (result)
	);

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Finished with errors");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_block(input string name, input scrypt_cfg_pkg::block_t got,
		input scrypt_cfg_pkg::block_t exp);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_byte(input string name,
		input logic [scrypt_cfg_pkg::SHIFT_BITS-1:0] got,
		input logic [scrypt_cfg_pkg::SHIFT_BITS-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	task automatic draw_byte(output logic [7:0] b);
		for (int k = 0; k < 8; k++)
		begin
			b = {b[6:0], lfsr_state[0]};   // One step per bit, first bit ends up as the MSB
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic random_block(output host_bytes_t blk);
		for (int p = 0; p < HOST_BYTES; p++)
			draw_byte(blk[p]);
	endtask

	task automatic advance();
		@(posedge hash_clk);
		#DRIVE_DELAY;
	endtask

	// Shifts one block in while the previous contents come out on dout, top byte first
	task automatic exchange_block(input host_bytes_t in_bytes, output host_bytes_t out_bytes);
		for (int p = 0; p < HOST_BYTES; p++)
		begin
			out_bytes[p] = dout;
			din          = in_bytes[p];
			shift        = 1'b1;
			advance();
			check_flag("busy", busy, 1'b0);   // A stray start would show up here
			check_flag("result", result, 1'b0);
		end
		shift = 1'b0;
	endtask

	task automatic pulse_start(input logic expect_busy_before);
		check_flag("busy", busy, expect_busy_before);
		start = 1'b1;
		advance();
		start = 1'b0;
		check_flag("busy", busy, 1'b1);
	endtask

	// Returns one cycle after result, when the shift register holds the hash
	task automatic collect_result();
		int cycles;
		cycles = 0;
		while (result !== 1'b1)
		begin
			if (cycles == RESULT_TIMEOUT)
				fail_run("Timed out waiting for result from the engine");
			advance();
			cycles++;
		end
		check_flag("busy", busy, 1'b0);
		advance();
	endtask

	always @(posedge hash_clk)
	begin
		if (i_dut.i_checker.error_count != 0)
			fail_run("A protocol assertion in the bound checker failed");
	end

	initial
	begin
		host_bytes_t warm;
		host_bytes_t blk_a;
		host_bytes_t blk_b;
		host_bytes_t blk_c;
		host_bytes_t blk_d;
		host_bytes_t got;
		int cycles;
		din        = '0;
		shift      = 1'b0;
		start      = 1'b0;
		lfsr_state = LFSR_SEED;
		cycles     = 0;
		while (fsmreset !== 1'b0)
		begin
			if (cycles == RESET_TIMEOUT)
				fail_run("Reset was never released");
			advance();
			cycles++;
		end
		check_flag("busy", busy, 1'b0);
		check_flag("result", result, 1'b0);

		random_block(warm);   // Plain pass-through of the shift register
		exchange_block(warm, got);
		random_block(blk_a);
		exchange_block(blk_a, got);
		for (int p = 0; p < HOST_BYTES; p++)
			check_byte($sformatf("dout[%0d]", p), got[p], warm[p]);

		pulse_start(1'b0);
		collect_result();
		random_block(blk_b);   // Next block goes in while the first hash comes out
		exchange_block(blk_b, got);
		check_block("hash_a", bytes_to_block(got), romix(bytes_to_block(blk_a)));

		pulse_start(1'b0);
		collect_result();
		random_block(blk_c);
		exchange_block(blk_c, got);
		check_block("hash_b", bytes_to_block(got), romix(bytes_to_block(blk_b)));

		pulse_start(1'b0);
		repeat (8) advance();
		pulse_start(1'b1);   // Must be ignored while the hash is running
		collect_result();
		random_block(blk_d);
		exchange_block(blk_d, got);
		check_block("hash_c", bytes_to_block(got), romix(bytes_to_block(blk_c)));
		repeat (32)
		begin
			advance();
			check_flag("result", result, 1'b0);
			check_flag("busy", busy, 1'b0);
		end

		if (i_dut.i_checker.error_count == 0)
		begin
			$display("Finished with no errors");
			$finish;
		end
		else
			fail_run("A protocol assertion in the bound checker failed");
	end

endmodule

//--- all.f
+incdir+sim
src/scrypt_cfg_pkg.sv
src/romix_ctl_pkg.sv
src/salsa_core.sv
src/block_mixer.sv
src/scratchpad_bank.sv
src/romix_ctl.sv
src/salsa_engine.sv
sim/tb_clock_gen.sv
sim/salsa_engine_checker.sv
sim/tb_salsa_engine.sv

//--- Bender.yml
package:
  name: salsa_engine

sources:
  - files:
      - src/scrypt_cfg_pkg.sv
      - src/romix_ctl_pkg.sv
      - src/salsa_core.sv
      - src/block_mixer.sv
      - src/scratchpad_bank.sv
      - src/romix_ctl.sv
      - src/salsa_engine.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_clock_gen.sv
      - sim/salsa_engine_checker.sv
      - sim/tb_salsa_engine.sv
